/* hw/md_cart_pkg.sv */
//////////////////////////////
// Shared types and constants of the cartridge side.
// Load stream is 16 bit wide, byte addressed, one beat per write strobe.
// Product codes are compared as eight ASCII characters.
//////////////////////////////
`default_nettype none

package md_cart_pkg;

	//////////////////////////////
	// Widths
	localparam int load_index_w = 8;
	localparam int load_addr_w  = 25;
	localparam int word_w       = 16;
	localparam int va_w         = 23; // Word address, bits 23:1
	localparam int bank_w       = 5;
	localparam int num_banks    = 8;
	localparam int mask_w       = 11; // Mask bits 23:13

	//////////////////////////////
	// ROM header locations
	localparam logic [load_addr_w-1:0] hdr_region_addr   = 25'h1F0;
	localparam logic [load_addr_w-1:0] hdr_id_first_addr = 25'h182;
	localparam logic [load_addr_w-1:0] hdr_id_check_addr = 25'h18C;

	localparam logic [63:0] pier_id_reprint = "T-574023";
	localparam logic [63:0] pier_id_first   = "T-574013";

	localparam int cart_index_bit = 6;
	localparam logic [2:0] page_reg_eeprom = 3'd4; // Pier serial EEPROM port, not mapped here

	typedef enum logic [1:0] {
		region_jp = 2'd0,
		region_us = 2'd1,
		region_eu = 2'd2
	} region_e;

	typedef enum logic [1:0] {
		map_linear = 2'd0,
		map_ssf    = 2'd1,
		map_pier   = 2'd2
	} map_mode_e;

	typedef struct packed {
		logic                    active; // Download level
		logic                    wr;
		logic [load_index_w-1:0] index;
		logic [load_addr_w-1:0]  addr;
		logic [word_w-1:0]       data;
	} load_write_t;

	typedef struct packed {
		logic [va_w-1:0]   va;
		logic [word_w-1:0] vdo;
		logic              rnw;
		logic              page_ce_n; // Time/page select, active low
	} cpu_bus_t;

	typedef struct packed {
		region_e region;
		logic    pier_quirk;
	} header_info_t;

	typedef struct packed {
		logic [mask_w-1:0] rom_mask;
		logic              cart_mode;
		logic              loading;
	} rom_map_t;

	// ROM or BIOS image in progress
	function automatic logic is_rom_load(input load_write_t ld);
		return ld.active && (ld.index[5:0] <= 6'd1);
	endfunction

endpackage

`default_nettype wire

/* hw/cart_header_sniffer.sv */
//////////////////////////////
// Watches the load stream for the region letter and the product code.
// Pier flag only set for cartridge loads; region decoded for any ROM load.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cart_header_sniffer (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  md_cart_pkg::load_write_t   load,
	output md_cart_pkg::header_info_t  hdr
);

	logic rom_load;
	logic beat;
	logic cart_beat;
	logic old_rom_load;
	logic [md_cart_pkg::load_addr_w-1:0] id_off;
	logic [63:0] cart_id;
	logic id_match;

	assign rom_load  = md_cart_pkg::is_rom_load(load);
	assign beat      = load.wr && rom_load;
	assign cart_beat = beat && load.index[md_cart_pkg::cart_index_bit];

	// Offset into the product code field
	assign id_off = load.addr - md_cart_pkg::hdr_id_first_addr;

	assign id_match = (cart_id == md_cart_pkg::pier_id_reprint) ||
		(cart_id == md_cart_pkg::pier_id_first);

	//////////////////////////////
	// Product code capture
	//////////////////////////////
	// Bytes arrive swapped within each word, first and last words are half used
	always_ff @(posedge clk_sys) begin
		if (cart_beat) begin
			case (id_off)
				25'd0: cart_id[63:56] <= load.data[15:8];
				25'd2: cart_id[55:40] <= {load.data[7:0], load.data[15:8]};
				25'd4: cart_id[39:24] <= {load.data[7:0], load.data[15:8]};
				25'd6: cart_id[23:8]  <= {load.data[7:0], load.data[15:8]};
				25'd8: cart_id[7:0]   <= load.data[7:0];
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// Region and Pier flag
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_rom_load   <= 1'b0;
			hdr.region     <= md_cart_pkg::region_jp;
			hdr.pier_quirk <= 1'b0;
		end else begin
			old_rom_load <= rom_load;

			// New load starts without the quirk
			if (rom_load && !old_rom_load)
				hdr.pier_quirk <= 1'b0;

			if (cart_beat && load.addr == md_cart_pkg::hdr_id_check_addr && id_match)
				hdr.pier_quirk <= 1'b1;

			if (beat && load.addr == md_cart_pkg::hdr_region_addr) begin
				if (load.data[7:0] == "J")
					hdr.region <= md_cart_pkg::region_jp;
				else if (load.data[7:0] == "U")
					hdr.region <= md_cart_pkg::region_us;
				else
					hdr.region <= md_cart_pkg::region_eu; // Anything else counts as Europe
			end
		end
	end

endmodule

`default_nettype wire

/* hw/rom_size_tracker.sv */
//////////////////////////////
// Builds the ROM address mask from the addresses seen during a load.
// Image must start at address 0, which clears the old mask.
// Mask only tracked in cartridge mode, a BIOS load keeps it.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rom_size_tracker (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  md_cart_pkg::load_write_t  load,
	output md_cart_pkg::rom_map_t     rmap
);

	logic rom_load;
	logic beat;
	logic is_cart;

	assign rom_load = md_cart_pkg::is_rom_load(load);
	assign beat     = load.wr && rom_load;
	assign is_cart  = load.index[md_cart_pkg::cart_index_bit];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rmap.rom_mask  <= '0;
			rmap.cart_mode <= 1'b0;
			rmap.loading   <= 1'b0;
		end else begin
			rmap.loading <= rom_load; // One cycle behind the stream

			if (beat) begin
				rmap.cart_mode <= is_cart;
				if (is_cart) begin
					// Restart at image base
					if (load.addr == '0)
						rmap.rom_mask <= '0;
					else
						rmap.rom_mask <= rmap.rom_mask | load.addr[23:13];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/bank_mapper.sv */
//////////////////////////////
// Eight 512 KB bank registers behind the time/page select.
// Writes land two clocks after the select falls; select must stay low that long.
// Reads of the page area return nothing here.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module bank_mapper (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  md_cart_pkg::header_info_t  hdr,
	input  md_cart_pkg::rom_map_t      rmap,
	input  md_cart_pkg::cpu_bus_t      cpu,
	output logic [md_cart_pkg::va_w-1:0] rom_addr
);

	md_cart_pkg::map_mode_e mode;

	logic sel_q;       // Registered page select
	logic sel_old;
	logic page_start;
	logic page_wr;
	logic [2:0] page_reg;
	logic [md_cart_pkg::bank_w-1:0] bank_q [md_cart_pkg::num_banks];
	logic [md_cart_pkg::bank_w-1:0] bank_sel;

	//////////////////////////////
	// Mapping mode
	//////////////////////////////
	always_comb begin
		if (hdr.pier_quirk)
			mode = md_cart_pkg::map_pier;
		else if (|rmap.rom_mask[10:9]) // Image above 4 MB
			mode = md_cart_pkg::map_ssf;
		else
			mode = md_cart_pkg::map_linear;
	end

	//////////////////////////////
	// Page select edge
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_q   <= 1'b1;
			sel_old <= 1'b1;
		end else begin
			sel_q   <= cpu.page_ce_n;
			sel_old <= sel_q;
		end
	end

	assign page_start = sel_old && !sel_q;
	assign page_wr    = page_start && !cpu.rnw;
	assign page_reg   = cpu.va[2:0]; // CPU A3:A1

	//////////////////////////////
	// Bank registers
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset || rmap.loading) begin
			for (int i = 0; i < md_cart_pkg::num_banks; i++)
				bank_q[i] <= md_cart_pkg::bank_w'(i);
		end else if (page_wr) begin
			case (mode)
				md_cart_pkg::map_pier: begin
					// Only 1..3 map to banks 5..7
					case (page_reg)
						3'd0: ;
						md_cart_pkg::page_reg_eeprom: ;
						default: begin
							if (!page_reg[2])
								bank_q[{1'b1, page_reg[1:0]}] <= {1'b0, cpu.vdo[3:0]};
						end
					endcase
				end
				md_cart_pkg::map_ssf: begin
					if (page_reg != 3'd0)
						bank_q[page_reg] <= cpu.vdo[4:0];
				end
				default: ; // Linear, banks stay put
			endcase
		end
	end

	//////////////////////////////
	// Address translation
	//////////////////////////////
	assign bank_sel = bank_q[cpu.va[20:18]]; // A21:A19 picks the bank

	assign rom_addr = {bank_sel, cpu.va[17:0]} & {rmap.rom_mask, 12'hFFF};

endmodule

`default_nettype wire

/* hw/md_cart_top.sv */
//////////////////////////////
// Cartridge side top: header sniffer, size tracker and bank mapper.
// No back-pressure on the load stream.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module md_cart_top (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  md_cart_pkg::load_write_t     load,
	input  md_cart_pkg::cpu_bus_t        cpu,
	output md_cart_pkg::region_e         region,
	output logic                         pier_quirk,
	output logic [md_cart_pkg::mask_w-1:0] rom_mask,
	output logic                         cart_mode,
	output logic [md_cart_pkg::va_w-1:0] rom_addr
);

	md_cart_pkg::header_info_t hdr;
	md_cart_pkg::rom_map_t     rmap;

	//////////////////////////////
	// Load stream watchers
	cart_header_sniffer u_sniffer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.load    (load),
		.hdr     (hdr)
	);

	rom_size_tracker u_tracker (
		.clk_sys (clk_sys),
		.reset   (reset),
		.load    (load),
		.rmap    (rmap)
	);

	//////////////////////////////
	// CPU side
	bank_mapper u_mapper (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.hdr      (hdr),
		.rmap     (rmap),
		.cpu      (cpu),
		.rom_addr (rom_addr)
	);

	assign region     = hdr.region;
	assign pier_quirk = hdr.pier_quirk;
	assign rom_mask   = rmap.rom_mask;
	assign cart_mode  = rmap.cart_mode;

endmodule

`default_nettype wire

/* verification/md_cart_checker.sv */
//////////////////////////////
// Cycle model of the cartridge side, compared on every falling edge.
// Inputs must change away from the rising edge.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module md_cart_checker (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         done,
	input  md_cart_pkg::load_write_t     load,
	input  md_cart_pkg::cpu_bus_t        cpu,
	input  md_cart_pkg::region_e         region,
	input  logic                         pier_quirk,
	input  logic [10:0]                  rom_mask,
	input  logic                         cart_mode,
	input  logic [22:0]                  rom_addr,
	output int                           value_errors,
	output int                           other_errors,
	output int                           checks
);

	logic [4:0] m_bank [8];
	logic [10:0] m_mask;
	md_cart_pkg::region_e m_region;
	logic m_pier;
	logic m_cart;
	logic m_loading;       // ROM load level, one cycle late
	logic ce_d1;
	logic ce_d2;
	logic [7:0] id_bytes [8]; // Header bytes 0x183..0x18A
	int pier_sets;
	int bank_writes;

	function automatic logic [10:0] exp_mask(input logic [10:0] mask, input logic [24:0] addr);
		if (addr == '0)
			return '0;
		return mask | addr[23:13];
	endfunction

	function automatic md_cart_pkg::region_e exp_region(input logic [7:0] letter);
		case (letter)
			"J": return md_cart_pkg::region_jp;
			"U": return md_cart_pkg::region_us;
			default: return md_cart_pkg::region_eu;
		endcase
	endfunction

	function automatic logic [22:0] exp_rom_addr(input logic [4:0] bank, input logic [22:0] va,
		input logic [10:0] mask);
		logic [22:0] unmasked;
		unmasked = {bank, va[17:0]}; // 512 KB windows
		return unmasked & {mask, 12'hFFF};
	endfunction

	function automatic logic is_pier_code();
		logic [63:0] code;
		code = {id_bytes[0], id_bytes[1], id_bytes[2], id_bytes[3],
			id_bytes[4], id_bytes[5], id_bytes[6], id_bytes[7]};
		return (code == "T-574023") || (code == "T-574013");
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, what, expected, actual);
		value_errors++;
	endtask

	//////////////////////////////
	// Reference model
	always @(posedge clk_sys) begin
		logic rom_load;
		logic beat;
		logic [2:0] pr;
		int lo;
		rom_load = load.active && (load.index[5:0] < 6'd2);
		beat     = rom_load && load.wr;
		pr       = cpu.va[2:0];
		lo       = int'(load.addr) - 'h183; // Byte at the even address
		if (reset) begin
			for (int i = 0; i < 8; i++)
				m_bank[i] = 5'(i);
			{m_mask, m_pier, m_cart, m_loading} = '0;
			m_region    = md_cart_pkg::region_jp;
			{ce_d1, ce_d2} = 2'b11;
			pier_sets   = 0;
			bank_writes = 0;
		end else begin
			if (m_loading) begin
				for (int i = 0; i < 8; i++)
					m_bank[i] = 5'(i);
			end else if (ce_d2 && !ce_d1 && !cpu.rnw) begin
				if (m_pier && pr >= 3'd1 && pr <= 3'd3) begin
					m_bank[int'(pr) + 4] = {1'b0, cpu.vdo[3:0]};
					bank_writes++;
				end else if (!m_pier && m_mask[10:9] != 2'b00 && pr != 3'd0) begin
					m_bank[pr] = cpu.vdo[4:0]; // SSF
					bank_writes++;
				end
			end
			ce_d2 = ce_d1;
			ce_d1 = cpu.page_ce_n;
			if (rom_load && !m_loading)
				m_pier = 1'b0;
			m_loading = rom_load;
			if (beat && load.index[6]) begin
				if (lo >= 0 && lo < 8)
					id_bytes[lo] = load.data[7:0];
				if (lo >= -1 && lo < 7)
					id_bytes[lo + 1] = load.data[15:8];
				if (load.addr == 25'h18C && is_pier_code()) begin
					m_pier = 1'b1;
					pier_sets++;
				end
				m_mask = exp_mask(m_mask, load.addr);
			end
			if (beat)
				m_cart = load.index[6];
			if (beat && load.addr == 25'h1F0)
				m_region = exp_region(load.data[7:0]);
		end
	end

	//////////////////////////////
	// Compare
	always @(negedge clk_sys) begin
		logic [22:0] want;
		want = exp_rom_addr(m_bank[cpu.va[20:18]], cpu.va, m_mask);
		if (reset) begin
			value_errors = 0;
			checks = 0;
		end else begin
			checks++;
			if (region !== m_region)
				report_mismatch("region", m_region, region);
			if (pier_quirk !== m_pier)
				report_mismatch("pier_quirk", m_pier, pier_quirk);
			if (rom_mask !== m_mask)
				report_mismatch("rom_mask", m_mask, rom_mask);
			if (cart_mode !== m_cart)
				report_mismatch("cart_mode", m_cart, cart_mode);
			if (rom_addr !== want)
				report_mismatch("rom_addr", want, rom_addr);
		end
	end

	// Stimulus must have reached the Pier and SSF paths
	always @(posedge done) begin
		other_errors = 0;
		if (pier_sets == 0) begin
			$display("Error: no load ever set the Pier flag, the Pier tests did not run");
			other_errors++;
		end
		if (bank_writes == 0) begin
			$display("Error: no page write ever changed a bank register");
			other_errors++;
		end
	end

endmodule

`default_nettype wire

/* verification/md_cart_asserts.sv */
//////////////////////////////
// Properties on the cartridge top, attached with bind.
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module md_cart_asserts (
	input logic                  clk_sys,
	input logic                  reset,
	input logic                  loading,
	input logic [22:0]           va,
	input md_cart_pkg::region_e  region,
	input logic                  pier_quirk,
	input logic [10:0]           rom_mask,
	input logic [22:0]           rom_addr
);

	int fail_count = 0;
	logic [22:0] addr_room;

	assign addr_room = {rom_mask, 12'hFFF};

	a_reset_values: assert property (@(posedge clk_sys)
		$fell(reset) |-> (!pier_quirk && region == md_cart_pkg::region_jp))
		else begin
			$error("pier_quirk or region not at reset value after reset");
			fail_count++;
		end

	// Mask only moves on a load beat, which also raises the registered load level
	a_mask_on_load: assert property (@(posedge clk_sys) disable iff (reset)
		!loading |-> $stable(rom_mask))
		else begin
			$error("rom_mask changed outside a ROM load");
			fail_count++;
		end

	// Banks back at 0..7 one edge after the registered load level
	a_banks_reset: assert property (@(posedge clk_sys) disable iff (reset)
		loading |=> (rom_addr == ({2'b00, va[20:18], va[17:0]} & addr_room)))
		else begin
			$error("bank registers not at reset values during a load");
			fail_count++;
		end

endmodule

bind md_cart_top md_cart_asserts u_asserts (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.loading    (rmap.loading),
	.va         (cpu.va),
	.region     (region),
	.pier_quirk (pier_quirk),
	.rom_mask   (rom_mask),
	.rom_addr   (rom_addr)
);

`default_nettype wire

/* verification/tb_md_cart.sv */
//////////////////////////////
// Testbench of the cartridge side. Inputs change 1 ns after the rising edge.
// Odd header byte in data[15:8], even byte in data[7:0].
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_md_cart;

	localparam int max_cycles = 20000;

	logic clk_sys = 1'b0;
	logic reset;
	logic done;
	md_cart_pkg::load_write_t load;
	md_cart_pkg::cpu_bus_t cpu;
	md_cart_pkg::region_e region;
	logic pier_quirk;
	logic [10:0] rom_mask;
	logic cart_mode;
	logic [22:0] rom_addr;
	int value_errors;
	int other_errors;
	int checks;
	int cycles = 0;
	logic [7:0] hdr_bytes [128]; // Bytes 0x180..0x1FF

	always #2 clk_sys = ~clk_sys;

	md_cart_top i_dut (
		.clk_sys (clk_sys), .reset (reset), .load (load), .cpu (cpu), .region (region),
		.pier_quirk (pier_quirk), .rom_mask (rom_mask), .cart_mode (cart_mode),
		.rom_addr (rom_addr)
	);

	md_cart_checker u_checker (
		.clk_sys (clk_sys), .reset (reset), .done (done), .load (load), .cpu (cpu),
		.region (region), .pier_quirk (pier_quirk), .rom_mask (rom_mask),
		.cart_mode (cart_mode), .rom_addr (rom_addr), .value_errors (value_errors),
		.other_errors (other_errors), .checks (checks)
	);

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic tick(input int n = 1);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	function automatic logic [15:0] fill_word(input logic [24:0] a);
		return a[15:0] ^ {7'h0, a[24:16]};
	endfunction

	task automatic make_header(input logic [63:0] code, input logic [7:0] letter);
		for (int i = 0; i < 128; i++)
			hdr_bytes[i] = 8'h20;
		for (int i = 0; i < 8; i++)
			hdr_bytes[3 + i] = code[63 - 8 * i -: 8]; // Product code at 0x183
		hdr_bytes[8'h70] = letter;                     // Region at 0x1F0
	endtask

	task automatic load_beat(input logic [24:0] addr, input logic [15:0] data);
		load.wr   = 1'b1;
		load.addr = addr;
		load.data = data;
		tick();
	endtask

	task automatic load_image(input logic [7:0] index, input logic [24:0] last);
		logic [24:0] a;
		load.active = 1'b1;
		load.index  = index;
		tick();
		load_beat(25'h0, fill_word(25'h0));
		for (int off = 'h180; off <= 'h1F0; off += 2)
			load_beat(25'(off), {hdr_bytes[off - 'h17F], hdr_bytes[off - 'h180]});
		repeat (16) begin
			a = 25'($urandom_range(last, 'h200)) & ~25'h1;
			load_beat(a, fill_word(a));
		end
		load_beat(last, fill_word(last));
		load.wr     = 1'b0;
		load.active = 1'b0;
		tick(2);
	endtask

	// Select low two cycles, then high two cycles
	task automatic page_access(input logic [2:0] page_reg, input logic [15:0] value,
		input logic rnw);
		cpu.va        = {20'($urandom), page_reg};
		cpu.vdo       = value;
		cpu.rnw       = rnw;
		cpu.page_ce_n = 1'b0;
		tick(2);
		cpu.page_ce_n = 1'b1;
		cpu.rnw       = 1'b1;
		tick(2);
	endtask

	task automatic sweep_va(input int n);
		repeat (n) begin
			cpu.va = 23'($urandom);
			tick();
		end
	endtask

	initial begin
		logic [7:0] letters [4];
		void'($urandom(65));
		letters = '{"J", "U", "E", "X"};
		load = '0;
		cpu = '0;
		cpu.rnw = 1'b1;
		cpu.page_ce_n = 1'b1;
		done = 1'b0;
		reset = 1'b1;
		tick(16);
		reset = 1'b0;
		tick(2);

		// Region letters over random image sizes up to 8 MB
		foreach (letters[i]) begin
			make_header("G-001122", letters[i]);
			load_image(8'h40, 25'($urandom_range('h7FFFFE, 'h200)) & ~25'h1);
			sweep_va(16);
		end

		// Page writes ignored up to 4 MB
		make_header("G-001122", "U");
		load_image(8'h40, 25'($urandom_range('h3FFFFE, 'h200)) & ~25'h1);
		repeat (8) begin
			page_access(3'($urandom), 16'($urandom), 1'b0);
			sweep_va(4);
		end

		// Pier product codes, then an ordinary one
		make_header("T-574023", "J");
		load_image(8'h40, 25'h7FFFFE);
		sweep_va(4);
		make_header("T-574013", "E");
		load_image(8'h40, 25'h7FFFFE);
		sweep_va(4);
		make_header("G-001122", "U");
		load_image(8'h40, 25'h3FFFFE);
		sweep_va(4);

		// SSF writes on a 6 MB image and a BIOS load that resets the banks
		load_image(8'h40, 25'h5FFFFE);
		repeat (12) begin
			page_access(3'($urandom_range(7, 1)), 16'($urandom), 1'b0);
			sweep_va(4);
		end
		page_access(3'd2, 16'h001F, 1'b1);
		load_image(8'h00, 25'h0FFFFE);
		sweep_va(16);

		// Pier layout with register 4
		make_header("T-574023", "J");
		load_image(8'h40, 25'h7FFFFE);
		repeat (10) begin
			page_access(3'($urandom_range(4, 1)), 16'($urandom), 1'b0);
			sweep_va(4);
		end
		page_access(3'd4, 16'h000B, 1'b0);
		cpu.va = {2'b00, 3'd4, 18'($urandom)}; // Window of bank 4
		tick(2);

		done = 1'b1;
		tick(2);
		$display("Checks %0d, value errors %0d, other errors %0d, assertion failures %0d",
			checks, value_errors, other_errors, i_dut.u_asserts.fail_count);
		if (value_errors + other_errors + i_dut.u_asserts.fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/md_cart_pkg.sv
hw/cart_header_sniffer.sv
hw/rom_size_tracker.sv
hw/bank_mapper.sv
hw/md_cart_top.sv
verification/md_cart_checker.sv
verification/md_cart_asserts.sv
verification/tb_md_cart.sv

/* Makefile */
# Verilator build, run, lint and clean for the cartridge side

.PHONY: all run lint clean

all: run

obj_dir/Vtb_md_cart: vlog.f $(wildcard hw/*.sv verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_md_cart -f vlog.f

run: obj_dir/Vtb_md_cart
	./obj_dir/Vtb_md_cart +verilator+error+limit+100 | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing --assert -Wall -Wno-fatal --top-module tb_md_cart -f vlog.f

clean:
	rm -rf obj_dir sim.log
